// File: Bender.yml
package:
  name: radio_block

sources:
  # Synthesizable RTL
  - include_dirs:
      - design
    files:
      - design/radio_pkg.sv
      - design/ctrlport_decoder.sv
      - design/radio_shared_regs.sv
      - design/rx_radio_ctrl.sv
      - design/rx_packetizer.sv
      - design/radio_block_top.sv

  # Testbench and bound checker
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/radio_block_checker.sv
      - dv/radio_block_tb.sv

// File: design/ctrlport_decoder.sv
// Control port address decoder
`include "radio_defines.svh"

module ctrlport_decoder
  import radio_pkg::*;
(
  input  logic                      radio_clk,
  input  logic                      radio_rst,
  // Upstream request and response
  input  logic                      req_wr,
  input  logic                      req_rd,
  input  logic [  `CTRL_ADDR_W-1:0] req_addr,
  input  logic [  `CTRL_DATA_W-1:0] req_data,
  output logic                      resp_ack,
  output ctrl_status_e              resp_status,
  output logic [  `CTRL_DATA_W-1:0] resp_data,
  // Shared window, read only
  output logic                      shared_req_rd,
  output logic [`SHARED_ADDR_W-1:0] shared_req_addr,
  input  logic                      shared_resp_ack,
  input  logic [  `CTRL_DATA_W-1:0] shared_resp_data,
  // Radio window
  output logic                      radio_req_wr,
  output logic                      radio_req_rd,
  output logic [ `RADIO_ADDR_W-1:0] radio_req_addr,
  output logic [  `CTRL_DATA_W-1:0] radio_req_data,
  input  logic                      radio_resp_ack,
  input  logic [  `CTRL_DATA_W-1:0] radio_resp_data
);

  localparam logic [`CTRL_ADDR_W-1:0] SHARED_BASE = `SHARED_BASE_ADDR;
  localparam logic [`CTRL_ADDR_W-1:0] RADIO_BASE  = `RADIO_BASE_ADDR;

  logic hit_shared;
  logic hit_radio;
  logic pend_err;
  logic pend_ok;
  logic local_ack;
  logic local_err;

  // Window match on the bits above each window size
  assign hit_shared = req_addr[`CTRL_ADDR_W-1:`SHARED_ADDR_W] ==
                      SHARED_BASE[`CTRL_ADDR_W-1:`SHARED_ADDR_W];
  assign hit_radio  = req_addr[`CTRL_ADDR_W-1:`RADIO_ADDR_W] ==
                      RADIO_BASE[`CTRL_ADDR_W-1:`RADIO_ADDR_W];

  // Request strobes and locally answered requests
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      shared_req_rd <= 1'b0;
      radio_req_wr  <= 1'b0;
      radio_req_rd  <= 1'b0;
      pend_err      <= 1'b0;
      pend_ok       <= 1'b0;
      local_ack     <= 1'b0;
      local_err     <= 1'b0;
    end else begin
      shared_req_rd <= req_rd & hit_shared;
      radio_req_wr  <= req_wr & hit_radio;
      radio_req_rd  <= req_rd & hit_radio;
      // Shared writes are dropped but still acked
      pend_ok       <= req_wr & hit_shared;
      pend_err      <= (req_wr | req_rd) & ~hit_shared & ~hit_radio;
      // Second stage lines up with target acks
      local_ack     <= pend_ok | pend_err;
      local_err     <= pend_err;
    end
  end

  // Offsets and write data
  always_ff @(posedge radio_clk) begin
    if (req_wr || req_rd) begin
      shared_req_addr <= req_addr[`SHARED_ADDR_W-1:0];
      radio_req_addr  <= req_addr[`RADIO_ADDR_W-1:0];
      radio_req_data  <= req_data;
    end
  end

  // Response merge
  assign resp_ack    = shared_resp_ack | radio_resp_ack | local_ack;
  assign resp_status = local_err ? CTRL_ERR_ADDR : CTRL_OKAY;

  always_comb begin
    if (shared_resp_ack) begin
      resp_data = shared_resp_data;
    end else if (radio_resp_ack) begin
      resp_data = radio_resp_data;
    end else begin
      resp_data = '0;
    end
  end

endmodule

// File: design/radio_block_top.sv
// Radio receive block top level
`include "radio_defines.svh"

module radio_block_top
  import radio_pkg::*;
(
  input  logic                     radio_clk,
  input  logic                     radio_rst,
  input  logic [`RADIO_TIME_W-1:0] radio_time,

  // Register control port
  input  logic                     req_wr,
  input  logic                     req_rd,
  input  logic [ `CTRL_ADDR_W-1:0] req_addr,
  input  logic [ `CTRL_DATA_W-1:0] req_data,
  output logic                     resp_ack,
  output ctrl_status_e             resp_status,
  output logic [ `CTRL_DATA_W-1:0] resp_data,

  // Radio samples
  input  logic [`RADIO_ITEM_W-1:0] radio_rx_data,
  input  logic                     radio_rx_stb,
  output logic                     rx_running,

  // Sample stream
  output logic [`RADIO_ITEM_W-1:0] rx_tdata,
  output logic                     rx_tlast,
  output logic                     rx_teob,
  output logic [`RADIO_TIME_W-1:0] rx_ttimestamp,
  output logic                     rx_tvalid,
  input  logic                     rx_tready
);

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------

  // Shared window requests
  logic                      shared_req_rd;
  logic [`SHARED_ADDR_W-1:0] shared_req_addr;
  logic                      shared_resp_ack;
  logic [  `CTRL_DATA_W-1:0] shared_resp_data;

  // Radio window requests
  logic                      radio_req_wr;
  logic                      radio_req_rd;
  logic [ `RADIO_ADDR_W-1:0] radio_req_addr;
  logic [  `CTRL_DATA_W-1:0] radio_req_data;
  logic                      radio_resp_ack;
  logic [  `CTRL_DATA_W-1:0] radio_resp_data;

  // Captured samples into the FIFO
  logic                      samp_valid;
  logic [ `RADIO_ITEM_W-1:0] samp_data;
  logic [ `RADIO_TIME_W-1:0] samp_time;
  logic                      samp_eob;
  logic [    `PKT_LEN_W-1:0] max_words_per_pkt;
  logic                      overflow;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------

  ctrlport_decoder u_decoder (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .req_wr           (req_wr),
    .req_rd           (req_rd),
    .req_addr         (req_addr),
    .req_data         (req_data),
    .resp_ack         (resp_ack),
    .resp_status      (resp_status),
    .resp_data        (resp_data),
    .shared_req_rd    (shared_req_rd),
    .shared_req_addr  (shared_req_addr),
    .shared_resp_ack  (shared_resp_ack),
    .shared_resp_data (shared_resp_data),
    .radio_req_wr     (radio_req_wr),
    .radio_req_rd     (radio_req_rd),
    .radio_req_addr   (radio_req_addr),
    .radio_req_data   (radio_req_data),
    .radio_resp_ack   (radio_resp_ack),
    .radio_resp_data  (radio_resp_data)
  );

  // Compat number and time readout
  radio_shared_regs u_shared (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .radio_time       (radio_time),
    .shared_req_rd    (shared_req_rd),
    .shared_req_addr  (shared_req_addr),
    .shared_resp_ack  (shared_resp_ack),
    .shared_resp_data (shared_resp_data)
  );

  // ----------------------------------------
  // Receive path
  // ----------------------------------------

  rx_radio_ctrl u_rx_ctrl (
    .radio_clk         (radio_clk),
    .radio_rst         (radio_rst),
    .radio_req_wr      (radio_req_wr),
    .radio_req_rd      (radio_req_rd),
    .radio_req_addr    (radio_req_addr),
    .radio_req_data    (radio_req_data),
    .radio_resp_ack    (radio_resp_ack),
    .radio_resp_data   (radio_resp_data),
    .radio_rx_data     (radio_rx_data),
    .radio_rx_stb      (radio_rx_stb),
    .radio_time        (radio_time),
    .rx_running        (rx_running),
    .samp_valid        (samp_valid),
    .samp_data         (samp_data),
    .samp_time         (samp_time),
    .samp_eob          (samp_eob),
    .max_words_per_pkt (max_words_per_pkt),
    .overflow          (overflow)
  );

  rx_packetizer u_packetizer (
    .radio_clk         (radio_clk),
    .radio_rst         (radio_rst),
    .samp_valid        (samp_valid),
    .samp_data         (samp_data),
    .samp_time         (samp_time),
    .samp_eob          (samp_eob),
    .max_words_per_pkt (max_words_per_pkt),
    .overflow          (overflow),
    .rx_tdata          (rx_tdata),
    .rx_tlast          (rx_tlast),
    .rx_teob           (rx_teob),
    .rx_ttimestamp     (rx_ttimestamp),
    .rx_tvalid         (rx_tvalid),
    .rx_tready         (rx_tready)
  );

endmodule

// File: design/radio_defines.svh
// Radio block constants
`ifndef RADIO_DEFINES_SVH
`define RADIO_DEFINES_SVH

// Datapath widths
`define RADIO_ITEM_W 32
`define RADIO_TIME_W 64

// Control port widths
`define CTRL_ADDR_W 20
`define CTRL_DATA_W 32

// Shared window, 16 bytes at the bottom of the map
`define SHARED_BASE_ADDR 20'h00000
`define SHARED_ADDR_W 4

// Radio window, one channel only
`define RADIO_BASE_ADDR 20'h01000
`define RADIO_ADDR_W 9

// Shared window offsets
`define REG_COMPAT_NUM 'h0
`define REG_TIME_LO 'h4
`define REG_TIME_HI 'h8

// Radio window offsets
`define REG_RX_CMD 'h0
`define REG_RX_CMD_NUM_WORDS 'h4
`define REG_RX_MAX_WORDS_PER_PKT 'h8
`define REG_RX_STATUS 'hC

// Compatibility number, major in the upper half
`define COMPAT_MAJOR 16'd1
`define COMPAT_MINOR 16'd0

// Receive buffering
`define RX_FIFO_DEPTH 16
`define PKT_LEN_W 16

`endif

// File: design/radio_pkg.sv
// Radio block types
package radio_pkg;

  // Control port response status
  typedef enum logic [1:0] {
    CTRL_OKAY     = 2'b00,
    CTRL_ERR_ADDR = 2'b01
  } ctrl_status_e;

  // Command code in REG_RX_CMD bits 1:0
  typedef enum logic [1:0] {
    RX_CMD_STOP   = 2'd0,
    RX_CMD_FINITE = 2'd1,
    RX_CMD_CONT   = 2'd2
  } rx_cmd_e;

  // Receive capture state
  typedef enum logic [1:0] {
    RX_IDLE       = 2'd0,
    RX_RUN_CONT   = 2'd1,
    RX_RUN_FINITE = 2'd2
  } rx_state_e;

endpackage

// File: design/radio_shared_regs.sv
// Shared radio registers
`include "radio_defines.svh"

module radio_shared_regs (
  input  logic                      radio_clk,
  input  logic                      radio_rst,
  input  logic [ `RADIO_TIME_W-1:0] radio_time,
  input  logic                      shared_req_rd,
  input  logic [`SHARED_ADDR_W-1:0] shared_req_addr,
  output logic                      shared_resp_ack,
  output logic [  `CTRL_DATA_W-1:0] shared_resp_data
);

  // Upper time word held from the last low-word read
  logic [`CTRL_DATA_W-1:0] time_hi;

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      shared_resp_ack <= 1'b0;
    end else begin
      shared_resp_ack <= shared_req_rd;
    end
  end

  // Read data, one cycle after the strobe
  always_ff @(posedge radio_clk) begin
    if (shared_req_rd) begin
      case (shared_req_addr)
        `REG_COMPAT_NUM: begin
          shared_resp_data <= {`COMPAT_MAJOR, `COMPAT_MINOR};
        end
        `REG_TIME_LO: begin
          shared_resp_data <= radio_time[`CTRL_DATA_W-1:0];
          // Keeps both halves from the same cycle
          time_hi          <= radio_time[`RADIO_TIME_W-1:`CTRL_DATA_W];
        end
        `REG_TIME_HI: begin
          shared_resp_data <= time_hi;
        end
        default: begin
          shared_resp_data <= '0;
        end
      endcase
    end
  end

endmodule

// File: design/rx_packetizer.sv
// Receive sample FIFO and packet framing
`include "radio_defines.svh"

module rx_packetizer (
  input  logic                     radio_clk,
  input  logic                     radio_rst,
  // Push side, no back-pressure
  input  logic                     samp_valid,
  input  logic [`RADIO_ITEM_W-1:0] samp_data,
  input  logic [`RADIO_TIME_W-1:0] samp_time,
  input  logic                     samp_eob,
  input  logic [   `PKT_LEN_W-1:0] max_words_per_pkt,
  output logic                     overflow,
  // Output stream
  output logic [`RADIO_ITEM_W-1:0] rx_tdata,
  output logic                     rx_tlast,
  output logic                     rx_teob,
  output logic [`RADIO_TIME_W-1:0] rx_ttimestamp,
  output logic                     rx_tvalid,
  input  logic                     rx_tready
);

  localparam int AW = $clog2(`RX_FIFO_DEPTH);

  // ----------------------------------------
  // Sample FIFO
  // ----------------------------------------

  logic [`RADIO_ITEM_W-1:0] mem_data [`RX_FIFO_DEPTH];
  logic [`RADIO_TIME_W-1:0] mem_time [`RX_FIFO_DEPTH];
  logic                     mem_eob  [`RX_FIFO_DEPTH];

  // Extra pointer bit tells full from empty
  logic [AW:0]           wr_ptr;
  logic [AW:0]           rd_ptr;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;
  logic                  head_eob;
  logic                  word_last;
  logic [`PKT_LEN_W-1:0] pkt_cnt;

  assign empty    = wr_ptr == rd_ptr;
  assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign push     = samp_valid & ~full;
  assign overflow = samp_valid & full;

  // Refill the output register when it is free or draining
  assign pop = ~empty & (~rx_tvalid | rx_tready);

  always_ff @(posedge radio_clk) begin
    if (push) begin
      mem_data[wr_ptr[AW-1:0]] <= samp_data;
      mem_time[wr_ptr[AW-1:0]] <= samp_time;
      mem_eob[wr_ptr[AW-1:0]]  <= samp_eob;
    end
  end

  // ----------------------------------------
  // Packet framing
  // ----------------------------------------

  assign head_eob  = mem_eob[rd_ptr[AW-1:0]];
  // Packet closes at the size limit or at end of burst
  assign word_last = head_eob || (pkt_cnt + 1'b1 >= max_words_per_pkt);

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      pkt_cnt   <= '0;
      rx_tvalid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr  <= rd_ptr + 1'b1;
        pkt_cnt <= word_last ? '0 : pkt_cnt + 1'b1;
      end
      if (pop) begin
        rx_tvalid <= 1'b1;
      end else if (rx_tready) begin
        rx_tvalid <= 1'b0;
      end
    end
  end

  // Output word, held until accepted
  always_ff @(posedge radio_clk) begin
    if (pop) begin
      rx_tdata <= mem_data[rd_ptr[AW-1:0]];
      rx_teob  <= head_eob;
      rx_tlast <= word_last;
      // Timestamp of the first word labels the packet
      if (pkt_cnt == '0) begin
        rx_ttimestamp <= mem_time[rd_ptr[AW-1:0]];
      end
    end
  end

endmodule

// File: design/rx_radio_ctrl.sv
// Receive control and capture
`include "radio_defines.svh"

module rx_radio_ctrl
  import radio_pkg::*;
(
  input  logic                     radio_clk,
  input  logic                     radio_rst,
  // Radio window registers
  input  logic                     radio_req_wr,
  input  logic                     radio_req_rd,
  input  logic [`RADIO_ADDR_W-1:0] radio_req_addr,
  input  logic [ `CTRL_DATA_W-1:0] radio_req_data,
  output logic                     radio_resp_ack,
  output logic [ `CTRL_DATA_W-1:0] radio_resp_data,
  // Radio samples
  input  logic [`RADIO_ITEM_W-1:0] radio_rx_data,
  input  logic                     radio_rx_stb,
  input  logic [`RADIO_TIME_W-1:0] radio_time,
  output logic                     rx_running,
  // Push side of the packetizer
  output logic                     samp_valid,
  output logic [`RADIO_ITEM_W-1:0] samp_data,
  output logic [`RADIO_TIME_W-1:0] samp_time,
  output logic                     samp_eob,
  output logic [   `PKT_LEN_W-1:0] max_words_per_pkt,
  input  logic                     overflow
);

  rx_state_e               state;
  rx_cmd_e                 cmd_code;
  logic                    cmd_valid;
  logic [`CTRL_DATA_W-1:0] num_words;
  logic [`CTRL_DATA_W-1:0] words_left;
  logic                    ovf_sticky;
  logic                    last_samp;

  assign rx_running = state != RX_IDLE;
  assign last_samp  = (state == RX_RUN_FINITE) && (words_left == 1);

  // ----------------------------------------
  // Register access
  // ----------------------------------------

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      radio_resp_ack    <= 1'b0;
      cmd_valid         <= 1'b0;
      num_words         <= '0;
      max_words_per_pkt <= `PKT_LEN_W'(64);
    end else begin
      radio_resp_ack <= radio_req_wr | radio_req_rd;
      // Command takes effect one cycle after its ack
      cmd_valid      <= radio_req_wr && (radio_req_addr == `REG_RX_CMD);
      if (radio_req_wr) begin
        case (radio_req_addr)
          `REG_RX_CMD_NUM_WORDS:     num_words <= radio_req_data;
          `REG_RX_MAX_WORDS_PER_PKT: max_words_per_pkt <= radio_req_data[`PKT_LEN_W-1:0];
          default:                   num_words <= num_words;
        endcase
      end
    end
  end

  // Command code and read data
  always_ff @(posedge radio_clk) begin
    if (radio_req_wr) begin
      cmd_code <= rx_cmd_e'(radio_req_data[1:0]);
    end
    if (radio_req_rd) begin
      case (radio_req_addr)
        `REG_RX_CMD_NUM_WORDS:     radio_resp_data <= num_words;
        `REG_RX_MAX_WORDS_PER_PKT: radio_resp_data <= `CTRL_DATA_W'(max_words_per_pkt);
        `REG_RX_STATUS:            radio_resp_data <= `CTRL_DATA_W'({ovf_sticky, rx_running});
        default:                   radio_resp_data <= '0;
      endcase
    end
  end

  // ----------------------------------------
  // Capture FSM
  // ----------------------------------------

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state      <= RX_IDLE;
      words_left <= '0;
      ovf_sticky <= 1'b0;
    end else begin
      // Burst countdown
      if (state == RX_RUN_FINITE && radio_rx_stb) begin
        words_left <= words_left - 1'b1;
        if (last_samp) begin
          state <= RX_IDLE;
        end
      end
      // Commands override the countdown
      if (cmd_valid) begin
        case (cmd_code)
          RX_CMD_STOP: begin
            state <= RX_IDLE;
          end
          RX_CMD_CONT: begin
            state      <= RX_RUN_CONT;
            ovf_sticky <= 1'b0;
          end
          RX_CMD_FINITE: begin
            // Zero-length burst never starts
            state      <= (num_words == '0) ? RX_IDLE : RX_RUN_FINITE;
            words_left <= num_words;
            ovf_sticky <= 1'b0;
          end
          default: begin
            state <= state;
          end
        endcase
      end
      // Lost sample stops the channel
      if (overflow) begin
        state      <= RX_IDLE;
        ovf_sticky <= 1'b1;
      end
    end
  end

  // Sample capture with its time
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      samp_valid <= 1'b0;
    end else begin
      samp_valid <= rx_running & radio_rx_stb;
    end
  end

  always_ff @(posedge radio_clk) begin
    if (radio_rx_stb) begin
      samp_data <= radio_rx_data;
      samp_time <= radio_time;
      samp_eob  <= last_samp;
    end
  end

endmodule

// File: dv/radio_block_checker.sv
// Radio block protocol checks
`include "radio_defines.svh"

module radio_block_checker (
  input logic                     radio_clk,
  input logic                     radio_rst,
  input logic                     req_wr,
  input logic                     req_rd,
  input logic                     resp_ack,
  input logic [`RADIO_ITEM_W-1:0] rx_tdata,
  input logic                     rx_tlast,
  input logic                     rx_teob,
  input logic [`RADIO_TIME_W-1:0] rx_ttimestamp,
  input logic                     rx_tvalid,
  input logic                     rx_tready
);

  // Count of failed assertions
  int unsigned fail_count = 0;

  // ----------------------------------------
  // Control port
  // ----------------------------------------

  // Ack follows its request by two cycles
  ack_after_req: assert property (
    @(posedge radio_clk) disable iff (radio_rst)
    $rose(resp_ack) |-> $past(req_wr || req_rd, 2)
  ) else begin
    $error("resp_ack rose without a request two cycles earlier");
    fail_count++;
  end

  // ----------------------------------------
  // Sample stream
  // ----------------------------------------

  // Word and flags hold while stalled
  stall_hold: assert property (
    @(posedge radio_clk) disable iff (radio_rst)
    rx_tvalid && !rx_tready |=> rx_tvalid && $stable(rx_tdata) && $stable(rx_tlast) &&
                                $stable(rx_teob) && $stable(rx_ttimestamp)
  ) else begin
    $error("stream word changed under back-pressure");
    fail_count++;
  end

  // End of burst always closes a packet
  eob_is_last: assert property (
    @(posedge radio_clk) disable iff (radio_rst)
    rx_tvalid && rx_teob |-> rx_tlast
  ) else begin
    $error("rx_teob seen without rx_tlast");
    fail_count++;
  end

endmodule

// File: dv/radio_block_tb.sv
// Radio block testbench
`include "radio_defines.svh"

module radio_block_tb
  import radio_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int DRV        = 10;
  localparam int RST_CYCLES = 8;
  localparam int ACK_LIMIT  = 20;
  localparam int WAIT_LIMIT = 2000;
  localparam int BURST_N    = 12;
  localparam int PKT_M      = 5;
  localparam int CONT_N     = 40;
  localparam int NUM_OPS    = 15;

  // tready patterns
  localparam int READY_HIGH = 0;
  localparam int READY_RAND = 1;
  localparam int READY_LOW  = 2;

  // Two radio times with distinct upper words
  localparam logic [`RADIO_TIME_W-1:0] T1 = 64'h0000_00a5_1234_5678;
  localparam logic [`RADIO_TIME_W-1:0] T2 = 64'h0000_00b6_9abc_def0;

  localparam logic [`CTRL_ADDR_W-1:0] CMD_ADDR    = `RADIO_BASE_ADDR + `REG_RX_CMD;
  localparam logic [`CTRL_ADDR_W-1:0] STATUS_ADDR = `RADIO_BASE_ADDR + `REG_RX_STATUS;

  // One register operation and its expected response
  typedef struct packed {
    logic                     wr;
    logic [ `CTRL_ADDR_W-1:0] addr;
    logic [ `CTRL_DATA_W-1:0] data;
    logic [`RADIO_TIME_W-1:0] rtime;
    ctrl_status_e             status;
    logic [ `CTRL_DATA_W-1:0] exp;
  } reg_op_t;

  logic                     radio_clk;
  logic                     radio_rst;
  logic [`RADIO_TIME_W-1:0] radio_time;
  logic                     req_wr;
  logic                     req_rd;
  logic [ `CTRL_ADDR_W-1:0] req_addr;
  logic [ `CTRL_DATA_W-1:0] req_data;
  logic                     resp_ack;
  ctrl_status_e             resp_status;
  logic [ `CTRL_DATA_W-1:0] resp_data;
  logic [`RADIO_ITEM_W-1:0] radio_rx_data;
  logic                     radio_rx_stb;
  logic                     rx_running;
  logic [`RADIO_ITEM_W-1:0] rx_tdata;
  logic                     rx_tlast;
  logic                     rx_teob;
  logic [`RADIO_TIME_W-1:0] rx_ttimestamp;
  logic                     rx_tvalid;
  logic                     rx_tready;

  integer  seed = 32'he245_470a;
  int      ready_mode;
  int      samp_seq;
  reg_op_t reg_table [NUM_OPS];

  // Sample model, driven and received
  logic [`RADIO_ITEM_W-1:0] exp_data [$];
  logic [`RADIO_TIME_W-1:0] exp_time [$];
  logic [`RADIO_ITEM_W-1:0] got_data [$];
  logic                     got_last [$];
  logic                     got_eob  [$];
  logic [`RADIO_TIME_W-1:0] got_ts   [$];

  radio_block_top u_dut (.*);

  bind radio_block_top radio_block_checker u_checker (
    .radio_clk     (radio_clk),
    .radio_rst     (radio_rst),
    .req_wr        (req_wr),
    .req_rd        (req_rd),
    .resp_ack      (resp_ack),
    .rx_tdata      (rx_tdata),
    .rx_tlast      (rx_tlast),
    .rx_teob       (rx_teob),
    .rx_ttimestamp (rx_ttimestamp),
    .rx_tvalid     (rx_tvalid),
    .rx_tready     (rx_tready)
  );

  // ----------------------------------------
  // Clock, tready and stream monitor
  // ----------------------------------------

  initial begin
    radio_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      radio_clk = ~radio_clk;
    end
  end

  // Random pattern high three cycles in four
  initial begin
    forever begin
      @(posedge radio_clk);
      #DRV;
      case (ready_mode)
        READY_RAND: rx_tready = ($random(seed) & 3) != 0;
        READY_LOW:  rx_tready = 1'b0;
        default:    rx_tready = 1'b1;
      endcase
    end
  end

  // Transfers sampled mid-cycle
  initial begin
    forever begin
      @(negedge radio_clk);
      if (!radio_rst && rx_tvalid && rx_tready) begin
        got_data.push_back(rx_tdata);
        got_last.push_back(rx_tlast);
        got_eob.push_back(rx_teob);
        got_ts.push_back(rx_ttimestamp);
      end
    end
  end

  // Protocol checker watch
  initial begin
    forever begin
      @(negedge radio_clk);
      if (u_dut.u_checker.fail_count != 0) begin
        $display("A protocol assertion in the bound checker did not hold");
        stop_on_error();
      end
    end
  end

  // ----------------------------------------
  // Tasks
  // ----------------------------------------

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    stop_on_error();
  endtask

  // One request, then wait for its ack
  task automatic reg_access(input logic wr, input logic [`CTRL_ADDR_W-1:0] addr,
                            input logic [`CTRL_DATA_W-1:0] data,
                            input ctrl_status_e exp_status,
                            input logic [`CTRL_DATA_W-1:0] exp_data_val);
    int waited;
    @(posedge radio_clk);
    #DRV;
    req_wr   = wr;
    req_rd   = ~wr;
    req_addr = addr;
    req_data = data;
    @(posedge radio_clk);
    #DRV;
    req_wr = 1'b0;
    req_rd = 1'b0;
    // Cycles since the request cycle
    waited = 1;
    @(negedge radio_clk);
    while (!resp_ack) begin
      waited++;
      assert (waited < ACK_LIMIT) else begin
        $display("No response to the request at address 0x%0h", addr);
        stop_on_error();
      end
      @(negedge radio_clk);
    end
    assert (waited == 2) else report_mismatch("resp_ack latency", waited, 2);
    assert (resp_status == exp_status) else report_mismatch("resp_status", resp_status,
                                                             exp_status);
    // Reads and unmapped writes return known data
    if (!wr || exp_status != CTRL_OKAY) begin
      assert (resp_data == exp_data_val) else report_mismatch("resp_data", resp_data,
                                                               exp_data_val);
    end
  endtask

  task automatic wait_running(input logic level);
    int n;
    n = 0;
    @(negedge radio_clk);
    while (rx_running !== level) begin
      n++;
      assert (n < WAIT_LIMIT) else begin
        $display("rx_running never reached %0b", level);
        stop_on_error();
      end
      @(negedge radio_clk);
    end
  endtask

  task automatic wait_words(input int count);
    int n;
    n = 0;
    @(posedge radio_clk);
    while (got_data.size() < count) begin
      n++;
      assert (n < WAIT_LIMIT) else begin
        $display("Only %0d of %0d stream words arrived", got_data.size(), count);
        stop_on_error();
      end
      @(posedge radio_clk);
    end
  endtask

  // Strobe one sample and log it with its time
  task automatic drive_sample();
    @(posedge radio_clk);
    #DRV;
    radio_time    = radio_time + 1'b1;
    radio_rx_stb  = 1'b1;
    radio_rx_data = 32'hc0de_0000 + samp_seq;
    samp_seq++;
    exp_data.push_back(radio_rx_data);
    exp_time.push_back(radio_time);
  endtask

  task automatic idle_cycle();
    @(posedge radio_clk);
    #DRV;
    radio_time   = radio_time + 1'b1;
    radio_rx_stb = 1'b0;
  endtask

  task automatic clear_model();
    @(posedge radio_clk);
    #DRV;
    exp_data.delete();
    exp_time.delete();
    got_data.delete();
    got_last.delete();
    got_eob.delete();
    got_ts.delete();
  endtask

  task automatic set_ready(input int mode);
    @(negedge radio_clk);
    ready_mode = mode;
  endtask

  // Data order, framing every m words, and packet timestamps
  task automatic check_stream(input int n, input int m, input logic burst);
    int   first;
    logic exp_last;
    @(posedge radio_clk);
    assert (got_data.size() == n) else begin
      $display("Stream carried %0d words where %0d were sent", got_data.size(), n);
      stop_on_error();
    end
    for (int i = 0; i < n; i++) begin
      first    = (i / m) * m;
      exp_last = ((i % m) == m - 1) || (burst && i == n - 1);
      assert (got_data[i] == exp_data[i])
        else report_mismatch($sformatf("rx_tdata[%0d]", i), got_data[i], exp_data[i]);
      assert (got_last[i] == exp_last)
        else report_mismatch($sformatf("rx_tlast[%0d]", i), got_last[i], exp_last);
      assert (got_eob[i] == (burst && i == n - 1))
        else report_mismatch($sformatf("rx_teob[%0d]", i), got_eob[i], burst && i == n - 1);
      assert (got_ts[i] == exp_time[first])
        else report_mismatch($sformatf("rx_ttimestamp[%0d]", i), got_ts[i], exp_time[first]);
    end
  endtask

  task automatic load_table();
    // Compat number, major 1 over minor 0
    reg_table[0]  = '{1'b0, `SHARED_BASE_ADDR + `REG_COMPAT_NUM, 32'h0, T1, CTRL_OKAY,
                      32'h0001_0000};
    // Time latch, high word belongs to the previous low read
    reg_table[1]  = '{1'b0, `SHARED_BASE_ADDR + `REG_TIME_LO, 32'h0, T1, CTRL_OKAY, T1[31:0]};
    reg_table[2]  = '{1'b0, `SHARED_BASE_ADDR + `REG_TIME_HI, 32'h0, T2, CTRL_OKAY, T1[63:32]};
    reg_table[3]  = '{1'b0, `SHARED_BASE_ADDR + `REG_TIME_LO, 32'h0, T2, CTRL_OKAY, T2[31:0]};
    reg_table[4]  = '{1'b0, `SHARED_BASE_ADDR + `REG_TIME_HI, 32'h0, T1, CTRL_OKAY, T2[63:32]};
    // Unmapped addresses
    reg_table[5]  = '{1'b0, 20'h00800, 32'h0, T1, CTRL_ERR_ADDR, 32'h0};
    reg_table[6]  = '{1'b1, 20'h20000, 32'hdead_beef, T1, CTRL_ERR_ADDR, 32'h0};
    reg_table[7]  = '{1'b0, 20'hfffff, 32'h0, T1, CTRL_ERR_ADDR, 32'h0};
    reg_table[8]  = '{1'b1, `SHARED_BASE_ADDR + `REG_TIME_LO, 32'h1234, T1, CTRL_OKAY, 32'h0};
    // Burst setup and readback
    reg_table[9]  = '{1'b1, `RADIO_BASE_ADDR + `REG_RX_CMD_NUM_WORDS, BURST_N, T1, CTRL_OKAY,
                      32'h0};
    reg_table[10] = '{1'b0, `RADIO_BASE_ADDR + `REG_RX_CMD_NUM_WORDS, 32'h0, T1, CTRL_OKAY,
                      BURST_N};
    reg_table[11] = '{1'b1, `RADIO_BASE_ADDR + `REG_RX_MAX_WORDS_PER_PKT, PKT_M, T1, CTRL_OKAY,
                      32'h0};
    reg_table[12] = '{1'b0, `RADIO_BASE_ADDR + `REG_RX_MAX_WORDS_PER_PKT, 32'h0, T1, CTRL_OKAY,
                      PKT_M};
    reg_table[13] = '{1'b0, STATUS_ADDR, 32'h0, T1, CTRL_OKAY, 32'h0};
    reg_table[14] = '{1'b0, `RADIO_BASE_ADDR + 'h10, 32'h0, T1, CTRL_OKAY, 32'h0};
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    radio_rst     = 1'b1;
    radio_time    = '0;
    req_wr        = 1'b0;
    req_rd        = 1'b0;
    req_addr      = '0;
    req_data      = '0;
    radio_rx_data = '0;
    radio_rx_stb  = 1'b0;
    rx_tready     = 1'b1;
    ready_mode    = READY_HIGH;
    samp_seq      = 0;
    load_table();
    repeat (RST_CYCLES) @(posedge radio_clk);
    #DRV;
    radio_rst = 1'b0;

    // Register table
    for (int i = 0; i < NUM_OPS; i++) begin
      @(posedge radio_clk);
      #DRV;
      radio_time = reg_table[i].rtime;
      reg_access(reg_table[i].wr, reg_table[i].addr, reg_table[i].data,
                 reg_table[i].status, reg_table[i].exp);
    end

    // Finite burst, tready high
    clear_model();
    reg_access(1'b1, CMD_ADDR, RX_CMD_FINITE, CTRL_OKAY, '0);
    wait_running(1'b1);
    repeat (BURST_N) drive_sample();
    idle_cycle();
    wait_words(BURST_N);
    wait_running(1'b0);
    reg_access(1'b0, STATUS_ADDR, '0, CTRL_OKAY, 32'h0);
    check_stream(BURST_N, PKT_M, 1'b1);

    // Continuous capture, sparse strobes, random tready
    clear_model();
    set_ready(READY_RAND);
    reg_access(1'b1, CMD_ADDR, RX_CMD_CONT, CTRL_OKAY, '0);
    wait_running(1'b1);
    for (int i = 0; i < CONT_N; i++) begin
      drive_sample();
      repeat (2 + i % 3) idle_cycle();
    end
    wait_words(CONT_N);
    reg_access(1'b1, CMD_ADDR, RX_CMD_STOP, CTRL_OKAY, '0);
    wait_running(1'b0);
    check_stream(CONT_N, PKT_M, 1'b0);

    // Overflow, stalled stream with a strobe every cycle
    clear_model();
    set_ready(READY_LOW);
    reg_access(1'b1, CMD_ADDR, RX_CMD_CONT, CTRL_OKAY, '0);
    wait_running(1'b1);
    while (rx_running) begin
      assert (exp_data.size() < WAIT_LIMIT) else begin
        $display("Capture never stopped on overflow");
        stop_on_error();
      end
      drive_sample();
      @(negedge radio_clk);
    end
    idle_cycle();
    // Overflow bit set, running clear
    reg_access(1'b0, STATUS_ADDR, '0, CTRL_OKAY, 32'b10);
    set_ready(READY_HIGH);
    wait_words(`RX_FIFO_DEPTH);
    for (int i = 0; i < `RX_FIFO_DEPTH; i++) begin
      assert (got_data[i] == exp_data[i])
        else report_mismatch($sformatf("rx_tdata[%0d]", i), got_data[i], exp_data[i]);
    end

    repeat (4) @(posedge radio_clk);
    if (u_dut.u_checker.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "%0d protocol assertions failed", u_dut.u_checker.fail_count);
    end
  end

endmodule

// File: project.f
+incdir+design
design/radio_pkg.sv
design/ctrlport_decoder.sv
design/radio_shared_regs.sv
design/rx_radio_ctrl.sv
design/rx_packetizer.sv
design/radio_block_top.sv
dv/radio_block_checker.sv
dv/radio_block_tb.sv
